// File: design/matLoadPkg.sv
// Dimensions, element type and control structs for the operand input memory
// Imported by every design file and by the testbench for widths and types
`default_nettype none

package matLoadPkg;

    // Matrix geometry, A is ROWS_A x K and B is K x COLS_B
    localparam int DATA_WIDTH = 12;
    localparam int ROWS_A     = 7;
    localparam int COLS_B     = 9;
    localparam int MAX_K      = 8;

    // K must hold the value MAX_K itself, hence the +1
    localparam int K_WIDTH = $clog2(MAX_K + 1);

    // Address widths cover the largest matrix of each kind
    localparam int A_ADDR_WIDTH = $clog2(ROWS_A * MAX_K);
    localparam int B_ADDR_WIDTH = $clog2(MAX_K * COLS_B);

    // RAM depths rounded up to a power of two
    localparam int A_DEPTH = 2 ** A_ADDR_WIDTH;
    localparam int B_DEPTH = 2 ** B_ADDR_WIDTH;

    // One signed matrix element
    typedef logic signed [DATA_WIDTH-1:0] element_t;

    // Inner dimension count
    typedef logic [K_WIDTH-1:0] kValue_t;

    // RAM addresses
    typedef logic [A_ADDR_WIDTH-1:0] aAddr_t;
    typedef logic [B_ADDR_WIDTH-1:0] bAddr_t;

    // User field that rides along with each stream word
    // newA sits in bit 0, K in the bits above it
    typedef struct packed {
        kValue_t kValue;
        logic    newA;
    } streamUser_t;

    // Address and write strobe for the A RAM
    typedef struct packed {
        aAddr_t addr;
        logic   wrEn;
    } aRamCtl_t;

    // Address and write strobe for the B RAM
    typedef struct packed {
        bAddr_t addr;
        logic   wrEn;
    } bRamCtl_t;

endpackage

`default_nettype wire

// File: design/operandRam.sv
// Single-port RAM for one operand matrix
// Read data appears one cycle after the address; writes land on the clock edge
`timescale 1ns/1ps
`default_nettype none

module operandRam
    import matLoadPkg::*;
#(
    parameter int DEPTH = A_DEPTH
) (
    input  logic                     clk,
    input  element_t                 wrData,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     wrEn,
    output element_t                 rdData
);

    // Storage array, no reset on contents
    element_t mem [DEPTH];

    // Registered read every cycle
    // A write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        rdData <= mem[addr];
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

endmodule

`default_nettype wire

// File: design/loadController.sv
// Load FSM for the operand memories
// Counts stream beats into the A and B RAMs, latches K and newA from the first beat,
// then hands both RAM address ports to the compute engine until it reports done
`timescale 1ns/1ps
`default_nettype none

module loadController
    import matLoadPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        streamValid,
    input  streamUser_t streamUser,
    input  logic        computeFinished,
    input  aAddr_t      aReadAddr,
    input  bAddr_t      bReadAddr,
    output logic        streamReady,
    output logic        matricesLoaded,
    output kValue_t     kOut,
    output aRamCtl_t    aCtl,
    output bRamCtl_t    bCtl
);

    // idle waits for the first beat of a load
    // loaded hands the RAMs to the compute side
    typedef enum logic [1:0] {
        idle,
        storeA,
        storeB,
        loaded
    } loadState_t;

    loadState_t state;
    loadState_t nextState;

    // Write pointers into each RAM
    aAddr_t aCount;
    bAddr_t bCount;

    // User field from the first beat, held for the whole load
    streamUser_t loadCfg;

    // Final write address of each matrix for the held K
    aAddr_t aLast;
    bAddr_t bLast;

    // Word taken from the stream this cycle
    logic beat;

    // Ready is a plain state level
    assign streamReady    = (state != loaded);
    assign matricesLoaded = (state == loaded);
    assign kOut           = loadCfg.kValue;

    assign beat = streamValid && streamReady;

    // M*K-1 and N*K-1, both fit the counter width for K up to MAX_K
    assign aLast = aAddr_t'(ROWS_A * loadCfg.kValue - 1);
    assign bLast = bAddr_t'(COLS_B * loadCfg.kValue - 1);

    // Next state
    always_comb begin
        nextState = state;
        unique case (state)
            idle: begin
                // newA picks which matrix comes first
                if (beat) begin
                    nextState = streamUser.newA ? storeA : storeB;
                end
            end
            storeA: begin
                // A done, B always follows
                if (beat && (aCount == aLast)) begin
                    nextState = storeB;
                end
            end
            storeB: begin
                if (beat && (bCount == bLast)) begin
                    nextState = loaded;
                end
            end
            loaded: begin
                if (computeFinished) begin
                    nextState = idle;
                end
            end
        endcase
    end

    // RAM address and write-enable multiplexing
    always_comb begin
        // Counters own the address ports while loading
        aCtl.addr = aCount;
        bCtl.addr = bCount;
        aCtl.wrEn = 1'b0;
        bCtl.wrEn = 1'b0;
        unique case (state)
            idle: begin
                // First word goes to address 0 of the chosen RAM
                aCtl.wrEn = beat && streamUser.newA;
                bCtl.wrEn = beat && !streamUser.newA;
            end
            storeA: begin
                aCtl.wrEn = beat;
            end
            storeB: begin
                bCtl.wrEn = beat;
            end
            loaded: begin
                // Compute engine drives the addresses, no writes
                aCtl.addr = aReadAddr;
                bCtl.addr = bReadAddr;
            end
        endcase
    end

    // State, counters and captured user field
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            aCount  <= '0;
            bCount  <= '0;
            loadCfg <= '0;
        end else begin
            state <= nextState;
            unique case (state)
                idle: begin
                    if (beat) begin
                        // Sample K and newA once per load
                        loadCfg <= streamUser;
                        if (streamUser.newA) begin
                            aCount <= aCount + 1'b1;
                        end else begin
                            bCount <= bCount + 1'b1;
                        end
                    end
                end
                storeA: begin
                    // Hold at the last address once A is full
                    if (beat && (aCount != aLast)) begin
                        aCount <= aCount + 1'b1;
                    end
                end
                storeB: begin
                    if (beat && (bCount != bLast)) begin
                        bCount <= bCount + 1'b1;
                    end
                end
                loaded: begin
                    // Rewind both pointers for the next load
                    if (computeFinished) begin
                        aCount <= '0;
                        bCount <= '0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/matrixInputMems.sv
// Operand input memory for the matrix-multiply engine
// Takes A and B from a valid/ready word stream and serves them to the compute side
// through two registered-read RAMs once matricesLoaded is high
`timescale 1ns/1ps
`default_nettype none

module matrixInputMems
    import matLoadPkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Incoming word stream
    input  element_t    streamData,
    input  streamUser_t streamUser,
    input  logic        streamValid,
    output logic        streamReady,

    // Compute-side read ports
    input  aAddr_t      aReadAddr,
    input  bAddr_t      bReadAddr,
    output element_t    aData,
    output element_t    bData,
    output kValue_t     kOut,

    // Load handshake with the compute engine
    output logic        matricesLoaded,
    input  logic        computeFinished
);

    // Controller to RAM port bundles
    aRamCtl_t aCtl;
    bRamCtl_t bCtl;

    // Load FSM and address muxing
    loadController u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .streamValid    (streamValid),
        .streamUser     (streamUser),
        .computeFinished(computeFinished),
        .aReadAddr      (aReadAddr),
        .bReadAddr      (bReadAddr),
        .streamReady    (streamReady),
        .matricesLoaded (matricesLoaded),
        .kOut           (kOut),
        .aCtl           (aCtl),
        .bCtl           (bCtl)
    );

    // Matrix A store
    // Both RAMs see the stream word, the write enables pick the target
    operandRam #(
        .DEPTH(A_DEPTH)
    ) u_aRam (
        .clk   (clk),
        .wrData(streamData),
        .addr  (aCtl.addr),
        .wrEn  (aCtl.wrEn),
        .rdData(aData)
    );

    // Matrix B store
    operandRam #(
        .DEPTH(B_DEPTH)
    ) u_bRam (
        .clk   (clk),
        .wrData(streamData),
        .addr  (bCtl.addr),
        .wrEn  (bCtl.wrEn),
        .rdData(bData)
    );

endmodule

`default_nettype wire

// File: testbench/matrixInputMems_asserts.sv
// Protocol checks for the load controller, attached by bind
// Any failure is reported with $error and counted for the testbench
`timescale 1ns/1ps
`default_nettype none

module loadControllerAsserts
    import matLoadPkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     streamReady,
    input logic     matricesLoaded,
    input logic     computeFinished,
    input kValue_t  kOut,
    input aRamCtl_t aCtl,
    input bRamCtl_t bCtl
);

    // Number of failed assertions, read by the testbench at the end of the run
    int failCount = 0;

    // Ready is simply the inverse of the loaded flag
    readyMirrorsLoaded: assert property (@(posedge clk) disable iff (reset)
        streamReady == !matricesLoaded)
    else begin
        $error("streamReady does not mirror matricesLoaded");
        failCount++;
    end

    // RAMs belong to the compute side once loaded
    noWriteWhileLoaded: assert property (@(posedge clk) disable iff (reset)
        matricesLoaded |-> (!aCtl.wrEn && !bCtl.wrEn))
    else begin
        $error("RAM write enable high while matricesLoaded");
        failCount++;
    end

    // Only a computeFinished pulse ends the loaded phase
    loadedFallsOnFinish: assert property (@(posedge clk) disable iff (reset)
        $fell(matricesLoaded) |-> $past(computeFinished))
    else begin
        $error("matricesLoaded fell without computeFinished");
        failCount++;
    end

    // K held steady while the engine works
    kHeldWhileLoaded: assert property (@(posedge clk) disable iff (reset)
        ($past(matricesLoaded) && matricesLoaded) |-> $stable(kOut))
    else begin
        $error("kOut changed while matricesLoaded");
        failCount++;
    end

endmodule

// Attach to every controller instance
bind loadController loadControllerAsserts u_asserts (
    .clk            (clk),
    .reset          (reset),
    .streamReady    (streamReady),
    .matricesLoaded (matricesLoaded),
    .computeFinished(computeFinished),
    .kOut           (kOut),
    .aCtl           (aCtl),
    .bCtl           (bCtl)
);

`default_nettype wire

// File: testbench/matrixInputMemsTb.sv
// Testbench for the operand input memory
// Streams A and B with random gaps, then reads both RAMs back against a model
`timescale 1ns/1ps
`default_nettype none

module matrixInputMemsTb
    import matLoadPkg::*;
;

    localparam logic [31:0] SEED = 32'hbb53d658;

    logic        clk;
    logic        reset;
    element_t    streamData;
    streamUser_t streamUser;
    logic        streamValid;
    logic        streamReady;
    aAddr_t      aReadAddr;
    bAddr_t      bReadAddr;
    element_t    aData;
    element_t    bData;
    kValue_t     kOut;
    logic        matricesLoaded;
    logic        computeFinished;

    // Expected RAM contents, filled as beats are accepted
    element_t modelA [A_DEPTH];
    element_t modelB [B_DEPTH];

    logic [31:0] rngState;

    matrixInputMems u_dut (.*);

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Stop the run with a reason
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Compare one observed value with the model
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected)
        else failRun($sformatf("error: %s actual 0x%0h expected 0x%0h", name, actual, expected));
    endtask

    // 32-bit xorshift step
    function automatic logic [31:0] scrambleState(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] randomWord();
        rngState = scrambleState(rngState);
        return rngState;
    endfunction

    // Wait for matricesLoaded, returns the number of cycles taken
    task automatic waitLoaded(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                failRun("timed out waiting for matricesLoaded after the last beat");
            end
        end while (!matricesLoaded);
    endtask

    // Stream one load, with A first when withA is set
    task automatic runLoad(input int k, input logic withA);
        int aBeats;
        int total;
        int idx;
        int cycles;
        int waited;
        logic [31:0] r;
        aBeats = withA ? ROWS_A * k : 0;
        total  = aBeats + COLS_B * k;
        idx    = 0;
        cycles = 0;
        while (idx < total) begin
            r = randomWord();
            @(posedge clk);
            // Roughly one cycle in four is a gap
            streamValid <= (r[1:0] != 2'b00);
            streamData  <= element_t'(r[27:16]);
            // Only the first beat carries the real K and newA
            if (idx == 0) begin
                streamUser <= streamUser_t'({kValue_t'(k), withA});
            end else begin
                streamUser <= streamUser_t'(r[8:4]);
            end
            @(negedge clk);
            checkValue("matricesLoaded", matricesLoaded, 0);
            // Taken at the coming edge
            if (streamValid && streamReady) begin
                if (idx < aBeats) begin
                    modelA[idx] = streamData;
                end else begin
                    modelB[idx - aBeats] = streamData;
                end
                idx++;
            end
            cycles++;
            if (cycles > total * 8 + 64) begin
                failRun("timed out streaming a load, beats were not accepted");
            end
        end
        @(posedge clk);
        streamValid <= 1'b0;
        waitLoaded(waited);
        // Loaded must show right after the edge that took the last beat
        checkValue("loadedDelay", waited, 1);
    endtask

    // Read one address from each RAM and compare one cycle later
    task automatic readCompare(input int aIdx, input int bIdx);
        @(posedge clk);
        aReadAddr <= aAddr_t'(aIdx);
        bReadAddr <= bAddr_t'(bIdx);
        @(posedge clk);
        @(negedge clk);
        checkValue("aData", aData, modelA[aIdx]);
        checkValue("bData", bData, modelB[bIdx]);
    endtask

    // Sweep every word of both RAMs, the smaller range wraps
    task automatic checkMemories(input int aWords, input int bWords);
        int words;
        words = (aWords > bWords) ? aWords : bWords;
        for (int i = 0; i < words; i++) begin
            readCompare(i % aWords, i % bWords);
        end
    endtask

    // Push beats while loaded, then re-read the addresses they were aimed at
    task automatic pushWhileLoaded(input int aWords, input int bWords);
        logic [31:0] r;
        int aHit [8];
        int bHit [8];
        for (int n = 0; n < 8; n++) begin
            r = randomWord();
            aHit[n] = r[23:16] % aWords;
            bHit[n] = r[31:24] % bWords;
            @(posedge clk);
            streamValid <= 1'b1;
            streamData  <= element_t'(r[11:0]);
            streamUser  <= streamUser_t'(r[16:12]);
            // Point the RAMs at live data, a stray write would corrupt it
            aReadAddr   <= aAddr_t'(aHit[n]);
            bReadAddr   <= bAddr_t'(bHit[n]);
            @(negedge clk);
            checkValue("streamReady", streamReady, 0);
        end
        @(posedge clk);
        streamValid <= 1'b0;
        for (int n = 0; n < 8; n++) begin
            readCompare(aHit[n], bHit[n]);
        end
    endtask

    // One-cycle computeFinished, ready again on the next cycle
    task automatic pulseFinish();
        @(posedge clk);
        computeFinished <= 1'b1;
        @(posedge clk);
        computeFinished <= 1'b0;
        @(negedge clk);
        checkValue("streamReady", streamReady, 1);
        checkValue("matricesLoaded", matricesLoaded, 0);
    endtask

    initial begin
        int kFirst;
        int kSecond;
        rngState        = SEED;
        reset           = 1'b1;
        streamData      = '0;
        streamUser      = '0;
        streamValid     = 1'b0;
        aReadAddr       = '0;
        bReadAddr       = '0;
        computeFinished = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset
        @(negedge clk);
        checkValue("streamReady", streamReady, 1);
        checkValue("matricesLoaded", matricesLoaded, 0);

        // Full load of A and B
        kFirst = 1 + randomWord() % MAX_K;
        runLoad(kFirst, 1'b1);
        checkValue("kOut", kOut, kFirst);
        checkMemories(ROWS_A * kFirst, COLS_B * kFirst);
        pushWhileLoaded(ROWS_A * kFirst, COLS_B * kFirst);
        pulseFinish();

        // B only, with a different K, A kept from before
        kSecond = 1 + (kFirst + randomWord() % (MAX_K - 1)) % MAX_K;
        runLoad(kSecond, 1'b0);
        checkValue("kOut", kOut, kSecond);
        checkMemories(ROWS_A * kFirst, COLS_B * kSecond);
        pulseFinish();

        if (u_dut.u_ctrl.u_asserts.failCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            failRun("concurrent assertions in the load controller failed");
        end
    end

endmodule

`default_nettype wire

// File: build.f
design/matLoadPkg.sv
design/operandRam.sv
design/loadController.sv
design/matrixInputMems.sv
testbench/matrixInputMems_asserts.sv
testbench/matrixInputMemsTb.sv

// File: Bender.yml
package:
  name: matrix_input_mems

sources:
  - files:
      - design/matLoadPkg.sv
      - design/operandRam.sv
      - design/loadController.sv
      - design/matrixInputMems.sv
  - target: test
    files:
      - testbench/matrixInputMems_asserts.sv
      - testbench/matrixInputMemsTb.sv
